// File: axi2spi_bridge.sv
`timescale 1ns/1ns

module axi2spi_bridge
    import axi_lite_pkg::*, spi_pkg::*;
(
    input  logic      sys_clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      irq,
    output logic      sclk,
    output logic      mosi,
    input  logic      miso
);

    spi_cmd_t    spi_cmd;      // start + tx byte
    spi_ctrl_u   spi_ctrl;     // live mode byte
    spi_result_t spi_result;   // busy, done, rx byte

    // bus side, register file and flags
    axi_lite_regs regs0 (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .spi_cmd    (spi_cmd),
        .spi_ctrl   (spi_ctrl),
        .spi_result (spi_result),
        .irq        (irq)
    );

    // pin side, one byte at a time
    spi_master_core core0 (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .spi_cmd    (spi_cmd),
        .spi_ctrl   (spi_ctrl),
        .spi_result (spi_result),
        .sclk       (sclk),
        .mosi       (mosi),
        .miso       (miso)
    );

endmodule

// File: axi_lite_pkg.sv
`include "spi_params.svh"

package axi_lite_pkg;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // master side, no prot
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0]     awaddr;
        logic                       awvalid;
        logic [`AXI_DATA_W-1:0]     wdata;
        logic [`AXI_DATA_W/8-1:0]   wstrb;   // only bit 0 matters here
        logic                       wvalid;
        logic                       bready;
        logic [`AXI_ADDR_W-1:0]     araddr;
        logic                       arvalid;
        logic                       rready;
    } axil_req_t;

    // slave side
    typedef struct packed {
        logic                       awready;
        logic                       wready;
        axil_resp_e                 bresp;
        logic                       bvalid;
        logic                       arready;
        logic [`AXI_DATA_W-1:0]     rdata;
        axil_resp_e                 rresp;
        logic                       rvalid;
    } axil_rsp_t;

endpackage

// File: axi_lite_regs.sv
`timescale 1ns/1ns
`include "spi_params.svh"

module axi_lite_regs
    import axi_lite_pkg::*, spi_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,
    input  axil_req_t   axil_req,
    output axil_rsp_t   axil_rsp,
    output spi_cmd_t    spi_cmd,
    output spi_ctrl_u   spi_ctrl,
    input  spi_result_t spi_result,
    output logic        irq
);

    // write channel state
    logic                   wr_rdy_q;   // awready and wready together
    logic                   bvalid_q;
    axil_resp_e             bresp_q;
    // read channel state
    logic                   ar_rdy_q;
    logic                   rvalid_q;
    axil_resp_e             rresp_q;
    logic [`AXI_DATA_W-1:0] rdata_q;
    // register contents
    spi_ctrl_u              ctrl_q;
    spi_ctrl_u              ctrl_wr;    // incoming byte with mstr cleared
    logic                   spif_q;
    logic                   wcol_q;
    logic [`SPI_DATA_W-1:0] rx_data_q;  // last received byte
    spi_status_t            stat;
    logic [`SPI_DATA_W-1:0] rd_byte;
    axil_resp_e             rd_resp;
    // handshakes and decode
    logic                   wr_hs, rd_hs;
    logic                   wr_en;
    logic                   wr_ctrl, wr_stat, wr_data;
    logic                   rd_ctrl, rd_stat, rd_data;

    assign wr_hs = axil_req.awvalid && axil_req.wvalid && wr_rdy_q;
    assign rd_hs = axil_req.arvalid && ar_rdy_q;
    assign wr_en = wr_hs && axil_req.wstrb[0];   // lane 0 or nothing

    assign wr_ctrl = (axil_req.awaddr == `REG_CTRL_OFS);
    assign wr_stat = (axil_req.awaddr == `REG_STAT_OFS);   // read only yet answers OKAY
    assign wr_data = (axil_req.awaddr == `REG_DATA_OFS);
    assign rd_ctrl = (axil_req.araddr == `REG_CTRL_OFS);
    assign rd_stat = (axil_req.araddr == `REG_STAT_OFS);
    assign rd_data = (axil_req.araddr == `REG_DATA_OFS);

    // ready one cycle after both valids and bvalid one cycle later
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wr_rdy_q <= 1'b0;
            bvalid_q <= 1'b0;
            bresp_q  <= OKAY;
        end else begin
            wr_rdy_q <= axil_req.awvalid && axil_req.wvalid && !wr_rdy_q && !bvalid_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
                bresp_q  <= (wr_ctrl || wr_stat || wr_data) ? OKAY : SLVERR;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // read side has the same two cycle shape
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ar_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
            rresp_q  <= OKAY;
            rdata_q  <= '0;
        end else begin
            ar_rdy_q <= axil_req.arvalid && !ar_rdy_q && !rvalid_q;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
                rresp_q  <= rd_resp;
                rdata_q  <= {{(`AXI_DATA_W-`SPI_DATA_W){1'b0}}, rd_byte};
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        ctrl_wr.raw    = axil_req.wdata[`SPI_DATA_W-1:0];
        ctrl_wr.f.rsvd = 1'b0;   // no slave mode
    end

    // status byte assembled by bit position
    always_comb begin
        stat                 = '0;
        stat[`STAT_SPIF_BIT] = spif_q;
        stat[`STAT_WCOL_BIT] = wcol_q;
        stat[`STAT_BUSY_BIT] = spi_result.busy;
    end

    always_comb begin
        rd_byte = '0;
        rd_resp = OKAY;
        if (rd_ctrl)      rd_byte = ctrl_q.raw;
        else if (rd_stat) rd_byte = stat;
        else if (rd_data) rd_byte = rx_data_q;
        else              rd_resp = SLVERR;   // unmapped
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ctrl_q    <= '0;
            spif_q    <= 1'b0;
            wcol_q    <= 1'b0;
            rx_data_q <= '0;
        end else begin
            if (wr_en && wr_ctrl)
                ctrl_q <= ctrl_wr;
            // any data access clears the flags
            if ((wr_en && wr_data) || (rd_hs && rd_data)) begin
                spif_q <= 1'b0;
                wcol_q <= 1'b0;
            end
            if (wr_en && wr_data && spi_result.busy)
                wcol_q <= 1'b1;   // byte dropped and shifter untouched
            if (spi_result.done) begin
                spif_q    <= 1'b1;   // wins over a same-cycle clear
                rx_data_q <= spi_result.rx_byte;
            end
        end
    end

    // kick the engine in the handshake cycle itself
    assign spi_cmd.start   = wr_en && wr_data && ctrl_q.f.spe && !spi_result.busy;
    assign spi_cmd.tx_byte = axil_req.wdata[`SPI_DATA_W-1:0];
    assign spi_ctrl        = ctrl_q;
    assign irq             = spif_q && ctrl_q.f.spie;

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_rdy_q;
        axil_rsp.wready  = wr_rdy_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = ar_rdy_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rdata   = rdata_q;
    end

    a_bvalid_hold: assert property (@(posedge sys_clk) disable iff (reset)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);

    a_rvalid_hold: assert property (@(posedge sys_clk) disable iff (reset)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

    // engine must report busy right after a start
    a_start_idle: assert property (@(posedge sys_clk) disable iff (reset)
        spi_cmd.start |=> spi_result.busy);

endmodule

// File: files.f
+incdir+.
axi_lite_pkg.sv
spi_pkg.sv
axi_lite_regs.sv
spi_master_core.sv
axi2spi_bridge.sv
tb_axi2spi.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_axi2spi -f files.f -o tb_axi2spi \
    && ./obj_dir/tb_axi2spi > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: spi_master_core.sv
`timescale 1ns/1ns
`include "spi_params.svh"

module spi_master_core
    import spi_pkg::*;
(
    input  logic        sys_clk,
    input  logic        reset,
    input  spi_cmd_t    spi_cmd,
    input  spi_ctrl_u   spi_ctrl,
    output spi_result_t spi_result,
    output logic        sclk,
    output logic        mosi,
    input  logic        miso
);

    // sequencing
    logic                   busy_q;
    logic                   done_q;
    logic [3:0]             div_cnt;    // sys_clk cycles left in this half period
    logic [3:0]             edge_cnt;   // sclk edges so far, 16 per byte
    logic                   sclk_q;
    logic                   mosi_q;
    // mode held for the whole byte
    logic                   cpha_q;
    logic                   dord_q;
    logic [1:0]             spr_q;
    // data path
    logic [`SPI_DATA_W-1:0] sr_q;       // tx bits not yet driven
    logic [`SPI_DATA_W-1:0] rx_q;
    logic                   edge_evt;
    logic                   drive_now;
    logic                   sample_now;
    logic                   launch;

    // half period length minus one, 1..15
    function automatic logic [3:0] half_m1(input logic [1:0] spr);
        logic [4:0] half;
        half = 5'((`SPI_DIV_BASE / 2) << spr);
        return 4'(half - 5'd1);
    endfunction

    function automatic logic head_bit(input logic [`SPI_DATA_W-1:0] x, input logic lsb_first);
        return lsb_first ? x[0] : x[`SPI_DATA_W-1];
    endfunction

    function automatic logic [`SPI_DATA_W-1:0] shift_out(input logic [`SPI_DATA_W-1:0] x,
                                                         input logic lsb_first);
        return lsb_first ? (x >> 1) : (x << 1);
    endfunction

    assign launch   = !busy_q && spi_cmd.start;
    assign edge_evt = busy_q && (div_cnt == 4'd0);   // sclk toggles here
    // even edge counts are leading edges
    assign drive_now  = edge_cnt[0] != cpha_q;
    assign sample_now = edge_cnt[0] == cpha_q;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            sclk_q   <= 1'b0;
            mosi_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                sclk_q <= spi_ctrl.f.cpol;   // idle level tracks cpol
                if (spi_cmd.start) begin
                    busy_q   <= 1'b1;
                    div_cnt  <= half_m1(spi_ctrl.f.spr);
                    edge_cnt <= '0;
                    if (!spi_ctrl.f.cpha)   // first bit must be out before edge 0
                        mosi_q <= head_bit(spi_cmd.tx_byte, spi_ctrl.f.dord);
                end
            end else if (div_cnt != 4'd0) begin
                div_cnt <= div_cnt - 4'd1;
            end else begin
                div_cnt  <= half_m1(spr_q);
                sclk_q   <= ~sclk_q;
                edge_cnt <= edge_cnt + 4'd1;
                if (drive_now)
                    mosi_q <= head_bit(sr_q, dord_q);
                if (edge_cnt == 4'd15) begin   // 16th edge, sclk back at cpol
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (launch) begin
            cpha_q <= spi_ctrl.f.cpha;
            dord_q <= spi_ctrl.f.dord;
            spr_q  <= spi_ctrl.f.spr;
            // cpha 0 already put the head bit on mosi
            sr_q   <= spi_ctrl.f.cpha ? spi_cmd.tx_byte
                                      : shift_out(spi_cmd.tx_byte, spi_ctrl.f.dord);
        end else if (edge_evt) begin
            if (drive_now)
                sr_q <= shift_out(sr_q, dord_q);
            if (sample_now)
                rx_q <= dord_q ? {miso, rx_q[`SPI_DATA_W-1:1]}
                               : {rx_q[`SPI_DATA_W-2:0], miso};
        end
    end

    assign sclk               = sclk_q;
    assign mosi               = mosi_q;
    assign spi_result.busy    = busy_q;
    assign spi_result.done    = done_q;
    assign spi_result.rx_byte = rx_q;   // complete in the done cycle

    // one cycle lag after a cpol change, then locked to it
    a_sclk_idle: assert property (@(posedge sys_clk) disable iff (reset)
        !busy_q && $stable(spi_ctrl.f.cpol) |-> sclk == spi_ctrl.f.cpol);

endmodule

// File: spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// bus widths
`define AXI_ADDR_W      32
`define AXI_DATA_W      32
`define SPI_DATA_W      8      // one spi character

// register map, 32-bit spaced, byte lane 0 only
`define REG_CTRL_OFS    32'h0000_0000
`define REG_STAT_OFS    32'h0000_0004
`define REG_DATA_OFS    32'h0000_0008

// sclk = sys_clk / (base << spr)
`define SPI_DIV_BASE    4

// status byte layout
`define STAT_SPIF_BIT   7      // transfer complete
`define STAT_WCOL_BIT   6      // data write while busy
`define STAT_BUSY_BIT   0      // engine shifting

`endif

// File: spi_pkg.sv
`include "spi_params.svh"

package spi_pkg;

    // mode byte, msb first: SPIE SPE DORD MSTR CPOL CPHA SPR1 SPR0
    typedef struct packed {
        logic       spie;   // irq enable
        logic       spe;    // engine enable
        logic       dord;   // 1 = lsb first
        logic       rsvd;   // mstr slot, always zero
        logic       cpol;   // sclk idle level
        logic       cpha;   // 1 = sample on trailing edge
        logic [1:0] spr;    // divider select
    } spi_ctrl_fields_t;

    // bus sees raw, engine sees fields
    typedef union packed {
        logic [`SPI_DATA_W-1:0] raw;
        spi_ctrl_fields_t       f;
    } spi_ctrl_u;

    typedef struct packed {
        logic       spif;
        logic       wcol;
        logic [4:0] rsvd;
        logic       busy;
    } spi_status_t;

    // regs -> engine
    typedef struct packed {
        logic                   start;   // single cycle
        logic [`SPI_DATA_W-1:0] tx_byte;
    } spi_cmd_t;

    // engine -> regs
    typedef struct packed {
        logic                   busy;
        logic                   done;    // single cycle, end of byte
        logic [`SPI_DATA_W-1:0] rx_byte;
    } spi_result_t;

endpackage

// File: tb_axi2spi.sv
`timescale 1ns/1ns
`include "spi_params.svh"

module tb_axi2spi
    import axi_lite_pkg::*, spi_pkg::*;
();

    localparam int STEP_LIMIT = 600;   // cycles per handshake step or slave wait
    localparam int POLL_LIMIT = 200;   // status polls per transfer

    logic        sys_clk  = 1'b0;
    logic        reset    = 1'b1;
    axil_req_t   axil_req = '0;
    axil_rsp_t   axil_rsp;
    logic        irq, sclk, mosi;
    logic        miso     = 1'b0;
    logic [31:0] lfsr     = 32'hb425;
    // reference model of the register block
    spi_ctrl_u   m_ctrl   = '0;
    logic        m_spif   = 1'b0;
    logic        m_wcol   = 1'b0;
    logic [7:0]  m_rx     = '0;
    // spi slave model
    logic [7:0]  s_tx     = '0;    // byte for miso picked by the test
    int          arm_req  = 0;
    int          arm_seen = 0;
    logic        s_active = 1'b0;
    logic [7:0]  s_sh     = '0;    // miso bits not yet driven
    logic [7:0]  s_rx     = '0;    // byte seen on mosi
    int          s_rx_cnt = 0;
    logic        sclk_prev = 1'b0;

    axi2spi_bridge dut0 (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .irq      (irq),
        .sclk     (sclk),
        .mosi     (mosi),
        .miso     (miso)
    );

    always #10 sys_clk = ~sys_clk;   // 20 ns period

    // galois form with taps x^32 x^22 x^2 x 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);   // one step per bit
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic wait_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        abort_run();
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input string name, input spi_ctrl_u got, input spi_ctrl_u exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input spi_status_t got,
                                input spi_status_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // status as the model sees it with busy from the caller
    function automatic spi_status_t model_status(input logic busy);
        spi_status_t s;
        s      = '0;
        s.spif = m_spif;
        s.wcol = m_wcol;
        s.busy = busy;
        return s;
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [7:0] data,
                             input logic [3:0] strb, output axil_resp_e resp);
        int n;
        @(negedge sys_clk);
        axil_req.awaddr  = addr;
        axil_req.wdata   = {24'h0, data};
        axil_req.wstrb   = strb;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        n = 0;
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            @(negedge sys_clk);
            n++;
            if (n > STEP_LIMIT) wait_timeout("awready and wready");
        end
        @(negedge sys_clk);   // address and data taken on the last posedge
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid) begin
            @(negedge sys_clk);
            n++;
            if (n > STEP_LIMIT) wait_timeout("bvalid");
        end
        resp = axil_rsp.bresp;
        axil_req.bready = 1'b1;
        @(negedge sys_clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [7:0] data,
                            output axil_resp_e resp);
        int n;
        @(negedge sys_clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        while (!axil_rsp.arready) begin
            @(negedge sys_clk);
            n++;
            if (n > STEP_LIMIT) wait_timeout("arready");
        end
        @(negedge sys_clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid) begin
            @(negedge sys_clk);
            n++;
            if (n > STEP_LIMIT) wait_timeout("rvalid");
        end
        data = axil_rsp.rdata[7:0];   // lane 0 only
        resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        @(negedge sys_clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [7:0] data);
        axil_resp_e resp;
        axi_write(addr, data, 4'h1, resp);
        check_resp("bresp", resp, OKAY);
    endtask

    task automatic reg_read(input logic [31:0] addr, output logic [7:0] data);
        axil_resp_e resp;
        axi_read(addr, data, resp);
        check_resp("rresp", resp, OKAY);
    endtask

    task automatic shift_miso();
        miso = m_ctrl.f.dord ? s_sh[0] : s_sh[7];
        s_sh = m_ctrl.f.dord ? (s_sh >> 1) : (s_sh << 1);
    endtask

    // slave acts half a sys_clk after each sclk edge
    always @(negedge sys_clk) begin
        if (arm_req != arm_seen) begin
            arm_seen = arm_req;
            s_active = 1'b1;
            s_sh     = s_tx;
            s_rx     = '0;
            s_rx_cnt = 0;
            if (!m_ctrl.f.cpha)
                shift_miso();   // first bit out before the leading edge
        end else if (s_active && sclk !== sclk_prev) begin
            // leading edge leaves the idle level and cpha picks the sample edge
            if ((sclk_prev == m_ctrl.f.cpol) != m_ctrl.f.cpha) begin
                s_rx     = m_ctrl.f.dord ? {mosi, s_rx[7:1]} : {s_rx[6:0], mosi};
                s_rx_cnt = s_rx_cnt + 1;
                s_active = (s_rx_cnt < 8);
            end else begin
                shift_miso();
            end
        end
        sclk_prev = sclk;
    end

    task automatic arm_slave();
        rand_byte(s_tx);
        arm_req = arm_req + 1;
    endtask

    task automatic wait_done();
        logic [7:0]  rd;
        spi_status_t st;
        int          n;
        n = 0;
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        while (st.busy) begin   // poll busy in status
            n++;
            if (n > POLL_LIMIT) wait_timeout("busy to clear");
            reg_read(`REG_STAT_OFS, rd);
            st = rd;
        end
        n = 0;
        while (s_active || arm_seen != arm_req) begin
            @(negedge sys_clk);
            n++;
            if (n > STEP_LIMIT) wait_timeout("the slave model to finish");
        end
        m_spif = 1'b1;
        m_rx   = s_tx;
    endtask

    task automatic run_transfer(input spi_ctrl_u c);
        logic [7:0]  tx;
        logic [7:0]  rd;
        spi_status_t st;
        reg_write(`REG_CTRL_OFS, c.raw);
        m_ctrl        = c;
        m_ctrl.f.rsvd = 1'b0;
        rand_byte(tx);
        arm_slave();
        reg_write(`REG_DATA_OFS, tx);
        m_spif = 1'b0;   // any data access clears both flags
        m_wcol = 1'b0;
        wait_done();
        check_byte("slave rx", s_rx, tx);
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status", st, model_status(1'b0));
        check_level("irq", irq, m_ctrl.f.spie);
        reg_read(`REG_DATA_OFS, rd);
        check_byte("rx data", rd, m_rx);
        m_spif = 1'b0;
        check_level("irq after data read", irq, 1'b0);
    endtask

    initial begin
        logic [7:0]  rd;
        logic [7:0]  tx;
        spi_ctrl_u   c;
        spi_ctrl_u   c_rd;
        spi_status_t st;
        axil_resp_e  resp;
        int          i;
        repeat (2) @(negedge sys_clk);   // two posedges in reset
        reset = 1'b0;
        check_level("irq", irq, 1'b0);
        check_level("sclk", sclk, 1'b0);
        check_level("mosi", mosi, 1'b0);
        check_level("bvalid", axil_rsp.bvalid, 1'b0);
        check_level("rvalid", axil_rsp.rvalid, 1'b0);
        reg_read(`REG_CTRL_OFS, rd);
        c_rd.raw = rd;
        check_ctrl("ctrl after reset", c_rd, m_ctrl);
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status after reset", st, model_status(1'b0));

        for (i = 0; i < 8; i++) begin
            rand_byte(c.raw);
            reg_write(`REG_CTRL_OFS, c.raw);
            m_ctrl        = c;
            m_ctrl.f.rsvd = 1'b0;   // mstr slot reads zero
            reg_read(`REG_CTRL_OFS, rd);
            c_rd.raw = rd;
            check_ctrl("ctrl readback", c_rd, m_ctrl);
        end

        // index walks all modes, orders and dividers
        for (i = 0; i < 40; i++) begin
            rand_byte(c.raw);
            c.f.spe  = 1'b1;
            c.f.cpha = i[0];
            c.f.cpol = i[1];
            c.f.dord = i[2];
            c.f.spr  = i[4:3];
            run_transfer(c);
        end

        // collision at the slowest divider
        c.raw    = 8'h00;
        c.f.spie = 1'b1;
        c.f.spe  = 1'b1;
        c.f.spr  = 2'd3;
        reg_write(`REG_CTRL_OFS, c.raw);
        m_ctrl = c;
        rand_byte(tx);
        arm_slave();
        reg_write(`REG_DATA_OFS, tx);
        rand_byte(rd);
        reg_write(`REG_DATA_OFS, rd);   // engine still shifting
        m_wcol = 1'b1;
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status while busy", st, model_status(1'b1));
        wait_done();
        check_byte("slave rx after collision", s_rx, tx);
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status after collision", st, model_status(1'b0));
        check_level("irq", irq, 1'b1);
        reg_read(`REG_DATA_OFS, rd);
        check_byte("rx data", rd, m_rx);
        m_spif = 1'b0;
        m_wcol = 1'b0;
        check_level("irq after data read", irq, 1'b0);
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status after data read", st, model_status(1'b0));

        // unmapped offsets
        axi_write(32'h0000_000C, 8'h5A, 4'h1, resp);
        check_resp("bresp unmapped", resp, SLVERR);
        axi_read(32'h0000_0010, rd, resp);
        check_resp("rresp unmapped", resp, SLVERR);
        // lane 0 strobe clear leaves control alone
        tx = ~m_ctrl.raw;   // every writable bit differs
        axi_write(`REG_CTRL_OFS, tx, 4'hE, resp);
        check_resp("bresp no strobe", resp, OKAY);
        reg_read(`REG_CTRL_OFS, rd);
        c_rd.raw = rd;
        check_ctrl("ctrl after masked write", c_rd, m_ctrl);

        // with the engine disabled a data write starts nothing
        rand_byte(c.raw);
        c.f.spe  = 1'b0;
        c.f.rsvd = 1'b0;
        reg_write(`REG_CTRL_OFS, c.raw);
        m_ctrl = c;
        rand_byte(tx);
        reg_write(`REG_DATA_OFS, tx);
        repeat (40) begin
            @(negedge sys_clk);
            check_level("sclk with spe clear", sclk, m_ctrl.f.cpol);
        end
        reg_read(`REG_STAT_OFS, rd);
        st = rd;
        check_status("status with spe clear", st, model_status(1'b0));

        $display("TEST PASSED");
        $finish;
    end

endmodule
